/* verilog/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 32

// byte lanes per word
`define LSU_LANES 4

`endif

/* verilog/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]  word_t;
    typedef logic [`LSU_XLEN-1:0]  addr_t;
    typedef logic [`LSU_LANES-1:0] strobe_t;
    typedef logic [1:0]            byte_off_t;

    typedef enum logic [2:0] {
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef struct packed {
        mem_op_e op;
        addr_t   base;
        word_t   offset;  // sign-extended immediate
        word_t   wdata;
    } lsu_cmd_t;

    typedef struct packed {
        mem_op_e   op;
        addr_t     addr1;
        addr_t     addr2;  // addr1 + 4
        byte_off_t byte_off;
        logic      split;
        strobe_t   strb1;
        strobe_t   strb2;
        word_t     wdata1;
        word_t     wdata2;
    } beat_plan_t;

    typedef struct packed {
        addr_t   addr;
        logic    wen;
        strobe_t wstrb;
        word_t   wdata;
    } mem_bus_t;

    typedef struct packed {
        mem_op_e   op;
        byte_off_t byte_off;
        word_t     lo_word;
        word_t     hi_word;
    } load_raw_t;

    typedef enum logic [2:0] {
        st_idle,
        st_req1,
        st_wait1,
        st_req2,
        st_wait2,
        st_out
    } seq_state_e;

endpackage

`default_nettype wire

/* verilog/lsu_request_decode.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_request_decode (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_req,
    input  wire lsu_pkg::lsu_cmd_t     cmd,
    output logic                       cmd_ack,
    input  wire                        plan_ready,
    output logic                       plan_valid,
    output lsu_pkg::beat_plan_t        plan
);

    lsu_pkg::addr_t          eff_addr;
    lsu_pkg::byte_off_t      off;
    lsu_pkg::strobe_t        base_strb;
    logic                    split;
    logic [2*`LSU_LANES-1:0] strb_pair;
    logic [2*`LSU_XLEN-1:0]  data_pair;
    lsu_pkg::beat_plan_t     plan_next;
    logic                    take;

    assign eff_addr = cmd.base + cmd.offset;
    assign off      = eff_addr[1:0];

    // lanes touched at offset 0, loads write nothing
    always_comb begin
        case (cmd.op)
            lsu_pkg::op_sb: base_strb = lsu_pkg::strobe_t'(1);
            lsu_pkg::op_sh: base_strb = lsu_pkg::strobe_t'(3);
            lsu_pkg::op_sw: base_strb = '1;
            default:        base_strb = '0;
        endcase
    end

    always_comb begin
        case (cmd.op)
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: split = (off == 2'd3);
            lsu_pkg::op_lw, lsu_pkg::op_sw:                  split = (off != 2'd0);
            default:                                         split = 1'b0;
        endcase
    end

    // low bytes land in the upper lanes of beat 1, spill goes to beat 2
    assign strb_pair = {{`LSU_LANES{1'b0}}, base_strb} << off;
    assign data_pair = {{`LSU_XLEN{1'b0}}, cmd.wdata} << {off, 3'b000};

    always_comb begin
        plan_next.op       = cmd.op;
        plan_next.addr1    = {eff_addr[`LSU_XLEN-1:2], 2'b00};
        plan_next.addr2    = {eff_addr[`LSU_XLEN-1:2], 2'b00} + lsu_pkg::addr_t'(4);
        plan_next.byte_off = off;
        plan_next.split    = split;
        plan_next.strb1    = strb_pair[`LSU_LANES-1:0];
        plan_next.strb2    = strb_pair[2*`LSU_LANES-1:`LSU_LANES];
        plan_next.wdata1   = data_pair[`LSU_XLEN-1:0];
        plan_next.wdata2   = data_pair[2*`LSU_XLEN-1:`LSU_XLEN];
    end

    // accept only with an empty (or draining) stage
    assign take = cmd_req && !cmd_ack && (!plan_valid || plan_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack    <= 1'b0;
            plan_valid <= 1'b0;
        end else if (take) begin
            cmd_ack    <= 1'b1;
            plan_valid <= 1'b1;
        end else begin
            if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;  // return to zero
            end
            if (plan_ready) begin
                plan_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            plan <= plan_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_access_sequencer.sv */
`default_nettype none

module lsu_access_sequencer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        plan_valid,
    input  wire lsu_pkg::beat_plan_t   plan,
    output logic                       plan_ready,
    output logic                       mem_req,
    output lsu_pkg::mem_bus_t          mem,
    input  wire                        mem_ack,
    input  wire lsu_pkg::word_t        mem_rdata,
    output logic                       raw_valid,
    output lsu_pkg::load_raw_t         raw,
    input  wire                        raw_ready
);

    lsu_pkg::seq_state_e state;
    lsu_pkg::beat_plan_t plan_q;
    lsu_pkg::word_t      lo_q;
    lsu_pkg::word_t      hi_q;
    logic                second;
    logic                is_store;

    assign plan_ready = (state == lsu_pkg::st_idle);
    assign mem_req    = (state == lsu_pkg::st_req1) || (state == lsu_pkg::st_req2);
    assign raw_valid  = (state == lsu_pkg::st_out);
    assign second     = (state == lsu_pkg::st_req2) || (state == lsu_pkg::st_wait2);

    assign is_store = (plan_q.op == lsu_pkg::op_sb) ||
                      (plan_q.op == lsu_pkg::op_sh) ||
                      (plan_q.op == lsu_pkg::op_sw);

    // request fields come from the held plan, stable for the whole beat
    always_comb begin
        mem.addr  = second ? plan_q.addr2  : plan_q.addr1;
        mem.wen   = is_store;
        mem.wstrb = second ? plan_q.strb2  : plan_q.strb1;
        mem.wdata = second ? plan_q.wdata2 : plan_q.wdata1;
    end

    always_comb begin
        raw.op       = plan_q.op;
        raw.byte_off = plan_q.byte_off;
        raw.lo_word  = lo_q;
        raw.hi_word  = hi_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::st_idle;
        end else begin
            case (state)
                lsu_pkg::st_idle: begin
                    if (plan_valid) begin
                        state <= lsu_pkg::st_req1;
                    end
                end
                lsu_pkg::st_req1: begin
                    if (mem_ack) begin
                        state <= lsu_pkg::st_wait1;
                    end
                end
                lsu_pkg::st_wait1: begin
                    // ack must fall before the next beat or the response
                    if (!mem_ack) begin
                        state <= plan_q.split ? lsu_pkg::st_req2 : lsu_pkg::st_out;
                    end
                end
                lsu_pkg::st_req2: begin
                    if (mem_ack) begin
                        state <= lsu_pkg::st_wait2;
                    end
                end
                lsu_pkg::st_wait2: begin
                    if (!mem_ack) begin
                        state <= lsu_pkg::st_out;
                    end
                end
                lsu_pkg::st_out: begin
                    if (raw_ready) begin
                        state <= lsu_pkg::st_idle;  // stores come through here too
                    end
                end
                default: state <= lsu_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (plan_valid && plan_ready) begin
            plan_q <= plan;
        end
        if (mem_req && mem_ack) begin
            if (second) begin
                hi_q <= mem_rdata;
            end else begin
                lo_q <= mem_rdata;
            end
        end
        if (state == lsu_pkg::st_wait1 && !mem_ack && !plan_q.split) begin
            hi_q <= lo_q;  // single beat, mirror low word
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_load_align.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_load_align (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        raw_valid,
    input  wire lsu_pkg::load_raw_t    raw,
    output logic                       raw_ready,
    output logic                       rsp_req,
    output lsu_pkg::word_t             rsp_data,
    input  wire                        rsp_ack
);

    logic [2*`LSU_XLEN-1:0] pair;
    lsu_pkg::word_t         shifted;
    lsu_pkg::word_t         value;
    logic                   take;

    // held ack blocks the next transfer
    assign raw_ready = !rsp_req && !rsp_ack;
    assign take      = raw_valid && raw_ready;

    assign pair    = {raw.hi_word, raw.lo_word};
    assign shifted = lsu_pkg::word_t'(pair >> {raw.byte_off, 3'b000});

    always_comb begin
        case (raw.op)
            lsu_pkg::op_lb:  value = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::op_lbu: value = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            lsu_pkg::op_lh:  value = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::op_lhu: value = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            lsu_pkg::op_lw:  value = shifted;
            default:         value = '0;  // stores answer zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_req <= 1'b0;
        end else if (take) begin
            rsp_req <= 1'b1;
        end else if (rsp_ack) begin
            rsp_req <= 1'b0;
        end
    end

    // only loads while rsp_req is low, so data holds during the exchange
    always_ff @(posedge clk) begin
        if (take) begin
            rsp_data <= value;
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`default_nettype none

module lsu_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_req,
    input  wire lsu_pkg::lsu_cmd_t     cmd,
    output logic                       cmd_ack,
    output logic                       mem_req,
    output lsu_pkg::mem_bus_t          mem,
    input  wire                        mem_ack,
    input  wire lsu_pkg::word_t        mem_rdata,
    output logic                       rsp_req,
    output lsu_pkg::word_t             rsp_data,
    input  wire                        rsp_ack
);

    logic                plan_valid;
    logic                plan_ready;
    lsu_pkg::beat_plan_t plan;
    logic                raw_valid;
    logic                raw_ready;
    lsu_pkg::load_raw_t  raw;

    lsu_request_decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .plan_ready (plan_ready),
        .plan_valid (plan_valid),
        .plan       (plan)
    );

    lsu_access_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .plan_valid (plan_valid),
        .plan       (plan),
        .plan_ready (plan_ready),
        .mem_req    (mem_req),
        .mem        (mem),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .raw_valid  (raw_valid),
        .raw        (raw),
        .raw_ready  (raw_ready)
    );

    lsu_load_align align_i (
        .clk        (clk),
        .rst        (rst),
        .raw_valid  (raw_valid),
        .raw        (raw),
        .raw_ready  (raw_ready),
        .rsp_req    (rsp_req),
        .rsp_data   (rsp_data),
        .rsp_ack    (rsp_ack)
    );

endmodule

`default_nettype wire

/* verification/lsu_assertions.sv */
`default_nettype none

module lsu_assertions (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_req,
    input  wire lsu_pkg::lsu_cmd_t     cmd,
    input  wire                        cmd_ack,
    input  wire                        mem_req,
    input  wire lsu_pkg::mem_bus_t     mem,
    input  wire                        mem_ack,
    input  wire                        rsp_req,
    input  wire lsu_pkg::word_t        rsp_data,
    input  wire                        rsp_ack,
    input  wire                        plan_ready
);

    int               fails = 0;
    lsu_pkg::addr_t   prev_addr;
    lsu_pkg::strobe_t prev_strb;
    logic             prev_beat;

    // last finished beat of the current command, forgotten once the sequencer idles
    always_ff @(posedge clk) begin
        if (rst || plan_ready) begin
            prev_beat <= 1'b0;
        end else if (mem_req && mem_ack) begin
            prev_beat <= 1'b1;
            prev_addr <= mem.addr;
            prev_strb <= mem.wstrb;
        end
    end

    // req held until its ack
    cmd_hold_a: assert property (@(posedge clk) disable iff (rst)
        cmd_req && !cmd_ack |=> cmd_req)
    else begin
        fails++;
        $error("cmd_req dropped before cmd_ack");
    end
    mem_hold_a: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
    else begin
        fails++;
        $error("mem_req dropped before mem_ack");
    end
    rsp_hold_a: assert property (@(posedge clk) disable iff (rst)
        rsp_req && !rsp_ack |=> rsp_req)
    else begin
        fails++;
        $error("rsp_req dropped before rsp_ack");
    end

    cmd_stable_a: assert property (@(posedge clk) disable iff (rst)
        cmd_req |=> !cmd_req || $stable(cmd))
    else begin
        fails++;
        $error("cmd changed while cmd_req high");
    end
    mem_stable_a: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req || $stable(mem))
    else begin
        fails++;
        $error("mem changed while mem_req high");
    end
    rsp_stable_a: assert property (@(posedge clk) disable iff (rst)
        rsp_req |=> !rsp_req || $stable(rsp_data))
    else begin
        fails++;
        $error("rsp_data changed while rsp_req high");
    end

    // next beat only after the previous ack is gone
    mem_rtz_a: assert property (@(posedge clk) disable iff (rst) $rose(mem_req) |-> !mem_ack)
    else begin
        fails++;
        $error("mem_req rose while mem_ack still high");
    end

    // second beat of a split goes to the next word, in other lanes
    split_addr_a: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) && prev_beat |-> mem.addr == prev_addr + 32'd4)
    else begin
        fails++;
        $error("second beat address is not the next word");
    end
    split_strb_a: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) && prev_beat |-> (mem.wstrb & prev_strb) == '0)
    else begin
        fails++;
        $error("beat strobes overlap");
    end

    reset_a: assert property (@(posedge clk) $fell(rst) |-> !cmd_ack && !mem_req && !rsp_req)
    else begin
        fails++;
        $error("handshake outputs high right after reset");
    end

endmodule

bind lsu_top lsu_assertions asrt_i (
    .clk        (clk),
    .rst        (rst),
    .cmd_req    (cmd_req),
    .cmd        (cmd),
    .cmd_ack    (cmd_ack),
    .mem_req    (mem_req),
    .mem        (mem),
    .mem_ack    (mem_ack),
    .rsp_req    (rsp_req),
    .rsp_data   (rsp_data),
    .rsp_ack    (rsp_ack),
    .plan_ready (plan_ready)
);

`default_nettype wire

/* verification/lsu_tb.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    localparam int n_random = 60;
    localparam int n_cmds   = 41 + n_random;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               cmd_req = 1'b0;
    lsu_pkg::lsu_cmd_t  cmd = '0;
    logic               cmd_ack;
    logic               mem_req;
    lsu_pkg::mem_bus_t  mem;
    logic               mem_ack = 1'b0;
    lsu_pkg::word_t     mem_rdata = '0;
    logic               rsp_req;
    lsu_pkg::word_t     rsp_data;
    logic               rsp_ack = 1'b0;

    lsu_pkg::word_t     mem_words [64];
    logic [7:0]         ref_mem [256];  // byte image, updated at issue
    lsu_pkg::word_t     exp_q [$];
    string              name_q [$];
    int                 errors = 0;
    int                 beats = 0;
    int                 exp_beats = 0;
    int                 mem_wait;
    logic               mem_armed = 1'b0;
    int                 rsp_wait;
    logic               rsp_armed = 1'b0;

    lsu_top dut_i (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic lsu_pkg::word_t fill_word(input int idx);
        return (32'h9e3779b9 * (idx + 1)) ^ (idx << 26);
    endfunction

    task automatic issue(input lsu_pkg::mem_op_e op, input lsu_pkg::addr_t base,
                         input lsu_pkg::word_t offset, input lsu_pkg::word_t wdata,
                         input string name);
        lsu_pkg::addr_t ea;
        lsu_pkg::word_t val;
        lsu_pkg::word_t expected;
        int size;
        ea = base + offset;
        size = (op inside {lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb}) ? 1 :
               (op inside {lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh}) ? 2 : 4;
        val = '0;
        for (int i = 0; i < size; i++) begin
            if (op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw}) begin
                ref_mem[(ea + i) % 256] = wdata[8*i +: 8];
            end else begin
                val[8*i +: 8] = ref_mem[(ea + i) % 256];
            end
        end
        case (op)
            lsu_pkg::op_lb: expected = {{24{val[7]}}, val[7:0]};
            lsu_pkg::op_lh: expected = {{16{val[15]}}, val[15:0]};
            default:        expected = val;  // stores give zero
        endcase
        exp_beats += (ea[1:0] + size > 4) ? 2 : 1;  // crosses a word
        exp_q.push_back(expected);
        name_q.push_back(name);
        cmd_req <= 1'b1;
        cmd     <= '{op: op, base: base, offset: offset, wdata: wdata};
        do @(posedge clk); while (!cmd_ack);
        cmd_req <= 1'b0;
        do @(posedge clk); while (cmd_ack);
    endtask

    task automatic check_response(input lsu_pkg::word_t actual);
        lsu_pkg::word_t expected;
        string name;
        if (exp_q.size() == 0) begin
            errors++;
            $display("response %h arrived with no command outstanding", actual);
        end else begin
            expected = exp_q.pop_front();
            name = name_q.pop_front();
            assert (actual == expected) else begin
                errors++;
                $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            end
        end
    endtask

    // memory with 0 to 3 cycles of ack delay
    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            mem_armed = 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req) begin
            if (!mem_armed) begin
                mem_wait = $urandom_range(3, 0);
                mem_armed = 1'b1;
            end
            if (mem_wait == 0) begin
                mem_rdata <= mem_words[mem.addr[7:2]];
                for (int l = 0; l < `LSU_LANES; l++) begin
                    if (mem.wen && mem.wstrb[l]) begin
                        mem_words[mem.addr[7:2]][8*l +: 8] = mem.wdata[8*l +: 8];
                    end
                end
                mem_ack <= 1'b1;
                mem_armed = 1'b0;
                beats++;
            end else begin
                mem_wait--;
            end
        end
    end

    // response side, random ack delay and random hold
    always @(posedge clk) begin
        if (rst) begin
            rsp_ack <= 1'b0;
            rsp_armed = 1'b0;
        end else if (rsp_ack) begin
            if (!rsp_req && $urandom_range(1, 0) == 0) begin
                rsp_ack <= 1'b0;
            end
        end else if (rsp_req) begin
            if (!rsp_armed) begin
                rsp_wait = $urandom_range(4, 0);
                rsp_armed = 1'b1;
            end
            if (rsp_wait == 0) begin
                check_response(rsp_data);
                rsp_ack <= 1'b1;
                rsp_armed = 1'b0;
            end else begin
                rsp_wait--;
            end
        end
    end

    initial begin
        #(n_cmds * 40 * 10);
        $display("timeout: run did not finish, %0d errors so far", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        lsu_pkg::word_t w;
        void'($urandom(32'hd7f245a1));
        for (int i = 0; i < 64; i++) begin
            w = fill_word(i);
            mem_words[i] = w;
            for (int b = 0; b < 4; b++) begin
                ref_mem[4*i + b] = w[8*b +: 8];
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 4; i++) begin
            issue(lsu_pkg::op_sw, 32'h1000 + 16 * i, -32'sd4, $urandom(), "aligned_word");
            issue(lsu_pkg::op_lw, 32'h1000 + 16 * i, -32'sd4, 32'h0, "aligned_word");
        end
        for (int off = 0; off < 4; off++) begin
            issue(lsu_pkg::op_sb, 32'h40, off, $urandom(), "sub_word");
            issue(lsu_pkg::op_sh, 32'h50, off, $urandom(), "sub_word");
            issue(lsu_pkg::op_lb, 32'h40, off, 32'h0, "sub_word");
            issue(lsu_pkg::op_lbu, 32'h40, off, 32'h0, "sub_word");
            issue(lsu_pkg::op_lh, 32'h50, off, 32'h0, "sub_word");
            issue(lsu_pkg::op_lhu, 32'h50, off, 32'h0, "sub_word");
        end
        for (int off = 1; off < 4; off++) begin
            issue(lsu_pkg::op_sw, 32'hc0, 16 * off + off, $urandom(), "split");
            issue(lsu_pkg::op_lw, 32'hc0, 16 * off + off, 32'h0, "split");
        end
        issue(lsu_pkg::op_sh, 32'hf0, 32'h3, 32'h0000_8c5a, "split");
        issue(lsu_pkg::op_lh, 32'hf0, 32'h3, 32'h0, "split");
        issue(lsu_pkg::op_lhu, 32'hf0, 32'h3, 32'h0, "split");

        // back to back, mixed ops and offsets
        for (int n = 0; n < n_random; n++) begin
            issue(lsu_pkg::mem_op_e'($urandom_range(7, 0)), $urandom_range(255, 0),
                  $urandom_range(31, 0) - 16, $urandom(), "back_pressure");
        end

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (beats == exp_beats) else begin
            errors++;
            $display("memory saw %0d beats but %0d were expected", beats, exp_beats);
        end
        for (int i = 0; i < 64; i++) begin
            w = {ref_mem[4*i + 3], ref_mem[4*i + 2], ref_mem[4*i + 1], ref_mem[4*i]};
            assert (mem_words[i] == w) else begin
                errors++;
                $display("MISMATCH final_memory expected %h actual %h", w, mem_words[i]);
            end
        end

        $display("errors: %0d  assertion failures: %0d", errors, dut_i.asrt_i.fails);
        if (errors == 0 && dut_i.asrt_i.fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_request_decode.sv
verilog/lsu_access_sequencer.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
verification/lsu_assertions.sv
verification/lsu_tb.sv
